// ==== Bender.yml ====
package:
  name: packet_switch

sources:
  - files:
      - verilog/switch_pkg.sv
      - verilog/switch_ifs.sv
      - verilog/desc_fifo.sv
      - verilog/port_ingress.sv
      - verilog/slot_allocator.sv
      - verilog/packet_buffer.sv
      - verilog/queue_manager.sv
      - verilog/egress_scheduler.sv
      - verilog/packet_switch.sv
  - target: test
    files:
      - testbench/packet_switch_checker.sv
      - testbench/packet_switch_tb.sv

// ==== packet_switch.f ====
verilog/switch_pkg.sv
verilog/switch_ifs.sv
verilog/desc_fifo.sv
verilog/port_ingress.sv
verilog/slot_allocator.sv
verilog/packet_buffer.sv
verilog/queue_manager.sv
verilog/egress_scheduler.sv
verilog/packet_switch.sv
testbench/packet_switch_checker.sv
testbench/packet_switch_tb.sv

// ==== testbench/packet_switch_checker.sv ====
`timescale 1ns/1ps

module packet_switch_checker (
    input logic                             clk,
    input logic                             rst_n,
    input logic [switch_pkg::NUM_PORTS-1:0] ready,
    input logic [switch_pkg::NUM_PORTS-1:0] rd_sop,
    input logic [switch_pkg::NUM_PORTS-1:0] rd_eop,
    input logic [switch_pkg::NUM_PORTS-1:0] rd_vld,
    input logic                             full,
    input logic                             almost_full
);

    int fail_cnt = 0;   // assertion failures so far.

    // a port only sees data while it is ready.
    vld_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_vld & ~ready) == '0)
        else begin
            $error("rd_vld high on a port whose ready is low");
            fail_cnt++;
        end

    vld_one_port: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(rd_vld))
        else begin
            $error("rd_vld high on more than one port");
            fail_cnt++;
        end

    marks_need_vld: assert property (@(posedge clk) disable iff (!rst_n)
        ((rd_sop | rd_eop) & ~rd_vld) == '0)
        else begin
            $error("rd_sop or rd_eop without rd_vld");
            fail_cnt++;
        end

    full_is_almost: assert property (@(posedge clk) disable iff (!rst_n)
        full |-> almost_full)   // zero free slots is below the level too.
        else begin
            $error("full high while almost_full is low");
            fail_cnt++;
        end

endmodule

bind packet_switch packet_switch_checker checker_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .ready       (ready),
    .rd_sop      (rd_sop),
    .rd_eop      (rd_eop),
    .rd_vld      (rd_vld),
    .full        (full),
    .almost_full (almost_full)
);

// ==== testbench/packet_switch_tb.sv ====
`timescale 1ns/1ps

module packet_switch_tb;

    logic                                                     clk;
    logic                                                     rst_n;
    logic [switch_pkg::NUM_PORTS-1:0]                         wr_sop;
    logic [switch_pkg::NUM_PORTS-1:0]                         wr_eop;
    logic [switch_pkg::NUM_PORTS-1:0]                         wr_vld;
    logic [switch_pkg::NUM_PORTS-1:0][switch_pkg::DATA_W-1:0] wr_data;
    logic [switch_pkg::NUM_PORTS-1:0]                         ready;
    logic                                                     full;
    logic                                                     almost_full;
    logic [switch_pkg::NUM_PORTS-1:0]                         rd_sop;
    logic [switch_pkg::NUM_PORTS-1:0]                         rd_eop;
    logic [switch_pkg::NUM_PORTS-1:0]                         rd_vld;
    logic [switch_pkg::NUM_PORTS-1:0][switch_pkg::DATA_W-1:0] rd_data;

    // expected packets, one queue per source and destination pair.
    logic [switch_pkg::DATA_W-1:0] exp_words [16][$];
    int                            exp_len   [16][$];
    int                            outstanding [switch_pkg::NUM_PORTS];   // per destination.
    int                            cur_q   [switch_pkg::NUM_PORTS];
    int                            cur_idx [switch_pkg::NUM_PORTS];
    int                            cur_len [switch_pkg::NUM_PORTS];
    int                            accepted;
    int                            delivered;
    int                            base;
    integer                        seed;
    logic [11:0]                   seq;
    bit                            traffic_done;
    logic [switch_pkg::DATA_W-1:0] drop_words [16];

    packet_switch dut_i (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_now(input string msg);
        $display("%s (time %0t)", msg, $time);
        abort_run();
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // header carries sequence, source and destination.
    task automatic build_packet(input int p, input int dest, input int len,
                                output logic [switch_pkg::DATA_W-1:0] words [16]);
        words[0] = {seq, p[1:0], dest[1:0]};
        seq      = seq + 1'b1;
        for (int k = 1; k < len; k++) begin
            words[k] = $random(seed);
        end
    endtask

    task automatic drive_packet(input int p, input int len,
                                input logic [switch_pkg::DATA_W-1:0] words [16]);
        for (int k = 0; k < len; k++) begin
            wr_vld[p]  = 1'b1;
            wr_sop[p]  = (k == 0);
            wr_eop[p]  = (k == len - 1);
            wr_data[p] = words[k];
            next_cycle();
        end
        wr_vld[p] = 1'b0;
        wr_sop[p] = 1'b0;
        wr_eop[p] = 1'b0;
    endtask

    task automatic send_packet(input int p, input int dest, input bit throttle);
        logic [switch_pkg::DATA_W-1:0] words [16];
        int len;
        int q;
        int t;
        len = 4 + ({$random(seed)} % 13);
        if (dest < 0) begin
            dest = {$random(seed)} % switch_pkg::NUM_PORTS;
        end
        t = 0;
        // a destination queue holds FIFO_DEPTH descriptors.
        while (throttle && (almost_full || outstanding[dest] >= switch_pkg::FIFO_DEPTH)) begin
            next_cycle();
            t++;
            if (t > 5000) fail_now("timeout waiting for room to start a packet");
        end
        build_packet(p, dest, len, words);
        q = p * switch_pkg::NUM_PORTS + dest;
        exp_len[q].push_back(len);
        for (int k = 0; k < len; k++) begin
            exp_words[q].push_back(words[k]);
        end
        outstanding[dest]++;
        accepted++;
        drive_packet(p, len, words);
    endtask

    task automatic run_port(input int p, input int n, input bit throttle, input bit spread);
        for (int i = 0; i < n; i++) begin
            repeat ({$random(seed)} % 4) next_cycle();
            send_packet(p, spread ? (i % switch_pkg::NUM_PORTS) : -1, throttle);
        end
    endtask

    task automatic toggle_ready();
        while (!traffic_done) begin
            ready = $random(seed);
            next_cycle();
        end
    endtask

    task automatic wait_drained(input string what);
        int t;
        t = 0;
        while (delivered != accepted || almost_full) begin
            next_cycle();
            t++;
            if (t > 5000) fail_now({"timeout waiting for ", what});
        end
    endtask

    task automatic take_word(input int p);
        logic [switch_pkg::DATA_W-1:0] w;
        int q;
        w = rd_data[p];
        check(rd_sop[p], cur_idx[p] == 0, "rd_sop on the first word");
        if (cur_idx[p] == 0) begin
            check(w[1:0], p, "header destination");
            q = w[3:2] * switch_pkg::NUM_PORTS + p;
            if (exp_len[q].size() == 0) begin
                fail_now("a packet came out that the model does not expect");
            end
            cur_q[p]   = q;
            cur_len[p] = exp_len[q].pop_front();
        end
        check(w, exp_words[cur_q[p]].pop_front(), "packet word");
        check(rd_eop[p], cur_idx[p] == cur_len[p] - 1, "rd_eop on the last word");
        if (cur_idx[p] == cur_len[p] - 1) begin
            cur_idx[p] = 0;
            outstanding[p]--;
            delivered++;
        end else begin
            cur_idx[p]++;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            check(dut_i.checker_i.fail_cnt, 0, "bound assertion failures");
            check(rd_vld & ~ready, 0, "rd_vld on a port without ready");
            check($onehot0(rd_vld), 1, "rd_vld on more than one port");
            for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
                if (rd_vld[p]) take_word(p);
            end
        end
    end

    initial begin
        seed         = 32'h6646;
        rst_n        = 1'b0;
        wr_sop       = '0;
        wr_eop       = '0;
        wr_vld       = '0;
        wr_data      = '0;
        ready        = '0;
        accepted     = 0;
        delivered    = 0;
        seq          = '0;
        traffic_done = 1'b0;
        for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
            outstanding[p] = 0;
            cur_idx[p]     = 0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        check(full, 0, "full after reset");
        check(almost_full, 0, "almost_full after reset");
        check(rd_sop | rd_eop | rd_vld, 0, "read strobes after reset");

        ready = '1;
        fork
            run_port(0, 30, 1'b1, 1'b0);
            run_port(1, 30, 1'b1, 1'b0);
            run_port(2, 30, 1'b1, 1'b0);
            run_port(3, 30, 1'b1, 1'b0);
        join
        wait_drained("traffic with ready high to drain");

        fork
            begin
                fork
                    run_port(0, 25, 1'b1, 1'b0);
                    run_port(1, 25, 1'b1, 1'b0);
                    run_port(2, 25, 1'b1, 1'b0);
                    run_port(3, 25, 1'b1, 1'b0);
                join
                traffic_done = 1'b1;
            end
            toggle_ready();
        join
        ready = '1;
        wait_drained("traffic with random ready to drain");

        // fill all 16 slots with the outputs stalled.
        ready = '0;
        base  = delivered;
        fork
            run_port(0, 4, 1'b0, 1'b1);
            run_port(1, 4, 1'b0, 1'b1);
            run_port(2, 4, 1'b0, 1'b1);
            run_port(3, 4, 1'b0, 1'b1);
        join
        for (int t = 0; !full; t++) begin
            if (t > 100) fail_now("timeout waiting for full with all slots taken");
            next_cycle();
        end
        build_packet(0, 1, 8, drop_words);   // no slot left, so never expected.
        drive_packet(0, 8, drop_words);
        repeat (20) next_cycle();
        check(delivered, base, "packets out while ready is low");
        ready = '1;
        wait_drained("the full buffer to drain");
        repeat (50) next_cycle();
        check(delivered - base, 16, "packets out of the full buffer");
        check(full, 0, "full after draining");
        check(almost_full, 0, "almost_full after draining");

        check(delivered, accepted, "delivered packet count");
        for (int q = 0; q < 16; q++) begin
            check(exp_len[q].size(), 0, "packets left in a model queue");
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== verilog/desc_fifo.sv ====
`timescale 1ns/1ps

module desc_fifo (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  switch_pkg::desc_t push_desc,
    input  logic              pop,
    output logic              empty,
    output switch_pkg::desc_t head
);

    switch_pkg::desc_t mem [switch_pkg::FIFO_DEPTH];

    // one extra bit tells full from empty.
    logic [switch_pkg::FIFO_AW:0] wr_ptr;
    logic [switch_pkg::FIFO_AW:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[switch_pkg::FIFO_AW-1:0]] <= push_desc;
        end
    end

    assign empty = (wr_ptr == rd_ptr);
    assign head  = mem[rd_ptr[switch_pkg::FIFO_AW-1:0]];   // fall-through.

endmodule

// ==== verilog/egress_scheduler.sv ====
`timescale 1ns/1ps

module egress_scheduler (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic [switch_pkg::NUM_PORTS-1:0]             q_empty,
    input  switch_pkg::desc_t [switch_pkg::NUM_PORTS-1:0] q_head,
    output logic [switch_pkg::NUM_PORTS-1:0]             q_pop,
    input  logic [switch_pkg::NUM_PORTS-1:0]             ready,
    output switch_pkg::slot_t                            rd_slot,
    output switch_pkg::len_t                             rd_addr,
    input  logic [switch_pkg::DATA_W-1:0]                rd_word,
    output logic                                         rel_vld,
    output switch_pkg::slot_t                            rel_slot,
    output logic [switch_pkg::NUM_PORTS-1:0]             rd_sop,
    output logic [switch_pkg::NUM_PORTS-1:0]             rd_eop,
    output logic [switch_pkg::NUM_PORTS-1:0]             rd_vld,
    output logic [switch_pkg::NUM_PORTS-1:0][switch_pkg::DATA_W-1:0] rd_data
);

    logic              busy_q;
    switch_pkg::port_t rr_q;
    switch_pkg::port_t port_q;
    switch_pkg::slot_t slot_q;
    switch_pkg::len_t  len_q;
    switch_pkg::len_t  idx_q;   // index of the word now on rd_word.
    logic              have_pick;
    switch_pkg::port_t pick;
    logic              start;
    logic              fire;
    logic              last;

    always_comb begin
        switch_pkg::port_t cand;
        have_pick = 1'b0;
        pick      = rr_q;
        for (int i = 0; i < switch_pkg::NUM_PORTS; i++) begin
            cand = rr_q + switch_pkg::port_t'(i);
            if (!have_pick && !q_empty[cand]) begin
                have_pick = 1'b1;
                pick      = cand;
            end
        end
    end

    assign start = !busy_q && have_pick;
    assign fire  = busy_q && ready[port_q];
    assign last  = (idx_q == len_q);

    // word 0 is read in the pop cycle, later words one ahead of the port.
    assign rd_slot = busy_q ? slot_q : q_head[pick].slot;
    assign rd_addr = !busy_q ? '0 : (fire ? idx_q + switch_pkg::len_t'(1) : idx_q);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            rr_q    <= '0;
            rel_vld <= 1'b0;
        end else begin
            rel_vld <= fire && last;
            if (start) begin
                busy_q <= 1'b1;
                rr_q   <= pick + 1'b1;
            end else if (fire && last) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        rel_slot <= slot_q;
        if (start) begin
            port_q <= pick;
            slot_q <= q_head[pick].slot;
            len_q  <= q_head[pick].len;
            idx_q  <= '0;
        end else if (busy_q) begin
            idx_q <= rd_addr;
        end
    end

    for (genvar p = 0; p < switch_pkg::NUM_PORTS; p++) begin : g_out
        assign q_pop[p]   = start && (pick == switch_pkg::port_t'(p));
        assign rd_vld[p]  = fire && (port_q == switch_pkg::port_t'(p));
        assign rd_sop[p]  = rd_vld[p] && (idx_q == '0);
        assign rd_eop[p]  = rd_vld[p] && last;
        assign rd_data[p] = rd_word;
    end

endmodule

// ==== verilog/packet_buffer.sv ====
`timescale 1ns/1ps

module packet_buffer (
    input  logic                          clk,
    buf_wr_if.memory                      wr [switch_pkg::NUM_PORTS],
    input  switch_pkg::slot_t             rd_slot,
    input  switch_pkg::len_t              rd_addr,
    output logic [switch_pkg::DATA_W-1:0] rd_word
);

    logic [switch_pkg::DATA_W-1:0] mem [switch_pkg::NUM_SLOTS*switch_pkg::SLOT_WORDS];

    logic [switch_pkg::NUM_PORTS-1:0] we;
    switch_pkg::word_addr_t           wa [switch_pkg::NUM_PORTS];
    logic [switch_pkg::DATA_W-1:0]    wd [switch_pkg::NUM_PORTS];
    switch_pkg::word_addr_t           ra;

    for (genvar p = 0; p < switch_pkg::NUM_PORTS; p++) begin : g_wr
        assign we[p] = wr[p].en;
        assign wa[p] = {wr[p].slot, wr[p].addr};
        assign wd[p] = wr[p].data;
    end

    assign ra = {rd_slot, rd_addr};

    // writers own distinct slots, so the ports never hit the same word.
    always_ff @(posedge clk) begin
        for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
            if (we[p]) begin
                mem[wa[p]] <= wd[p];
            end
        end
        rd_word <= mem[ra];
    end

endmodule

// ==== verilog/packet_switch.sv ====
`timescale 1ns/1ps

module packet_switch (
    input  logic                                                     clk,
    input  logic                                                     rst_n,
    input  logic [switch_pkg::NUM_PORTS-1:0]                         wr_sop,
    input  logic [switch_pkg::NUM_PORTS-1:0]                         wr_eop,
    input  logic [switch_pkg::NUM_PORTS-1:0]                         wr_vld,
    input  logic [switch_pkg::NUM_PORTS-1:0][switch_pkg::DATA_W-1:0] wr_data,
    input  logic [switch_pkg::NUM_PORTS-1:0]                         ready,
    output logic                                                     full,
    output logic                                                     almost_full,
    output logic [switch_pkg::NUM_PORTS-1:0]                         rd_sop,
    output logic [switch_pkg::NUM_PORTS-1:0]                         rd_eop,
    output logic [switch_pkg::NUM_PORTS-1:0]                         rd_vld,
    output logic [switch_pkg::NUM_PORTS-1:0][switch_pkg::DATA_W-1:0] rd_data
);

    alloc_if  alloc_bus [switch_pkg::NUM_PORTS] ();
    buf_wr_if wr_bus    [switch_pkg::NUM_PORTS] ();

    logic [switch_pkg::NUM_PORTS-1:0]              desc_vld;
    switch_pkg::desc_t [switch_pkg::NUM_PORTS-1:0] desc;
    switch_pkg::port_t [switch_pkg::NUM_PORTS-1:0] desc_dest;
    logic [switch_pkg::NUM_PORTS-1:0]              q_pop;
    logic [switch_pkg::NUM_PORTS-1:0]              q_empty;
    switch_pkg::desc_t [switch_pkg::NUM_PORTS-1:0] q_head;
    switch_pkg::slot_t                             rd_slot;
    switch_pkg::len_t                              rd_addr;
    logic [switch_pkg::DATA_W-1:0]                 rd_word;
    logic                                          rel_vld;
    switch_pkg::slot_t                             rel_slot;

    for (genvar p = 0; p < switch_pkg::NUM_PORTS; p++) begin : g_in
        port_ingress ingress_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .sop       (wr_sop[p]),
            .eop       (wr_eop[p]),
            .vld       (wr_vld[p]),
            .data      (wr_data[p]),
            .alloc     (alloc_bus[p]),
            .wr        (wr_bus[p]),
            .desc_vld  (desc_vld[p]),
            .desc      (desc[p]),
            .desc_dest (desc_dest[p])
        );
    end

    slot_allocator alloc_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc       (alloc_bus),
        .rel_vld     (rel_vld),
        .rel_slot    (rel_slot),
        .full        (full),
        .almost_full (almost_full)
    );

    packet_buffer buf_i (
        .clk     (clk),
        .wr      (wr_bus),
        .rd_slot (rd_slot),
        .rd_addr (rd_addr),
        .rd_word (rd_word)
    );

    queue_manager qm_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .desc_vld  (desc_vld),
        .desc      (desc),
        .desc_dest (desc_dest),
        .q_pop     (q_pop),
        .q_empty   (q_empty),
        .q_head    (q_head)
    );

    egress_scheduler egress_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .q_empty  (q_empty),
        .q_head   (q_head),
        .q_pop    (q_pop),
        .ready    (ready),
        .rd_slot  (rd_slot),
        .rd_addr  (rd_addr),
        .rd_word  (rd_word),
        .rel_vld  (rel_vld),
        .rel_slot (rel_slot),
        .rd_sop   (rd_sop),
        .rd_eop   (rd_eop),
        .rd_vld   (rd_vld),
        .rd_data  (rd_data)
    );

endmodule

// ==== verilog/port_ingress.sv ====
`timescale 1ns/1ps

module port_ingress (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          sop,
    input  logic                          eop,
    input  logic                          vld,
    input  logic [switch_pkg::DATA_W-1:0] data,
    alloc_if.ingress                      alloc,
    buf_wr_if.writer                      wr,
    output logic                          desc_vld,
    output switch_pkg::desc_t             desc,
    output switch_pkg::port_t             desc_dest
);

    logic                          d_vld;
    logic                          d_eop;
    logic [switch_pkg::DATA_W-1:0] d_data;
    logic                          keep_q;   // current packet holds a slot.
    switch_pkg::slot_t             slot_q;
    switch_pkg::len_t              addr_q;
    switch_pkg::port_t             dest_q;

    assign alloc.req = vld && sop;

    // the grant lines up with the delayed header word.
    assign wr.en   = d_vld && (alloc.grant ? alloc.ok : keep_q);
    assign wr.slot = alloc.grant ? alloc.slot : slot_q;
    assign wr.addr = alloc.grant ? '0 : addr_q;
    assign wr.data = d_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_vld    <= 1'b0;
            keep_q   <= 1'b0;
            desc_vld <= 1'b0;
        end else begin
            d_vld    <= vld;
            desc_vld <= wr.en && d_eop;
            if (alloc.grant) begin
                keep_q <= alloc.ok;   // a refused packet is dropped.
            end else if (wr.en && d_eop) begin
                keep_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        d_eop  <= eop;
        d_data <= data;
        if (alloc.req) begin
            dest_q <= data[1:0];   // header bits 1:0.
        end
        if (alloc.grant) begin
            slot_q <= alloc.slot;
        end
        if (wr.en) begin
            addr_q <= wr.addr + switch_pkg::len_t'(1);
        end
        if (wr.en && d_eop) begin
            desc.slot <= wr.slot;
            desc.len  <= wr.addr;
            desc_dest <= dest_q;
        end
    end

endmodule

// ==== verilog/queue_manager.sv ====
`timescale 1ns/1ps

module queue_manager (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic [switch_pkg::NUM_PORTS-1:0]             desc_vld,
    input  switch_pkg::desc_t [switch_pkg::NUM_PORTS-1:0] desc,
    input  switch_pkg::port_t [switch_pkg::NUM_PORTS-1:0] desc_dest,
    input  logic [switch_pkg::NUM_PORTS-1:0]             q_pop,
    output logic [switch_pkg::NUM_PORTS-1:0]             q_empty,
    output switch_pkg::desc_t [switch_pkg::NUM_PORTS-1:0] q_head
);

    logic [switch_pkg::NUM_PORTS-1:0]              pend_vld;
    switch_pkg::desc_t [switch_pkg::NUM_PORTS-1:0] pend_desc;
    switch_pkg::port_t [switch_pkg::NUM_PORTS-1:0] pend_dest;
    switch_pkg::port_t                             rr_q;   // ingress served this cycle.
    logic [switch_pkg::NUM_PORTS-1:0]              push;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_vld <= '0;
            rr_q     <= '0;
        end else begin
            rr_q <= rr_q + 1'b1;
            for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
                if (desc_vld[p]) begin
                    pend_vld[p] <= 1'b1;
                end else if (rr_q == switch_pkg::port_t'(p)) begin
                    pend_vld[p] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
            if (desc_vld[p]) begin
                pend_desc[p] <= desc[p];
                pend_dest[p] <= desc_dest[p];
            end
        end
    end

    for (genvar d = 0; d < switch_pkg::NUM_PORTS; d++) begin : g_dest
        assign push[d] = pend_vld[rr_q] && (pend_dest[rr_q] == switch_pkg::port_t'(d));

        desc_fifo fifo_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (push[d]),
            .push_desc (pend_desc[rr_q]),
            .pop       (q_pop[d]),
            .empty     (q_empty[d]),
            .head      (q_head[d])
        );
    end

endmodule

// ==== verilog/slot_allocator.sv ====
`timescale 1ns/1ps

module slot_allocator (
    input  logic              clk,
    input  logic              rst_n,
    alloc_if.allocator        alloc [switch_pkg::NUM_PORTS],
    input  logic              rel_vld,
    input  switch_pkg::slot_t rel_slot,
    output logic              full,
    output logic              almost_full
);

    logic [switch_pkg::NUM_SLOTS-1:0] free_map;
    logic [switch_pkg::NUM_SLOTS-1:0] avail;
    logic [switch_pkg::NUM_SLOTS-1:0] rel_mask;
    logic [switch_pkg::NUM_PORTS-1:0] req;
    logic [switch_pkg::NUM_PORTS-1:0] take_ok;
    switch_pkg::slot_t                take_slot [switch_pkg::NUM_PORTS];
    logic [switch_pkg::NUM_PORTS-1:0] grant_q;
    logic [switch_pkg::NUM_PORTS-1:0] ok_q;
    switch_pkg::slot_t                slot_q [switch_pkg::NUM_PORTS];
    switch_pkg::cnt_t                 free_cnt;
    switch_pkg::cnt_t                 n_taken;

    assign rel_mask = {{(switch_pkg::NUM_SLOTS-1){1'b0}}, rel_vld} << rel_slot;

    // each requester in port order takes the lowest slot still free.
    always_comb begin
        avail   = free_map;
        n_taken = '0;
        for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
            take_ok[p]   = 1'b0;
            take_slot[p] = '0;
            for (int s = 0; s < switch_pkg::NUM_SLOTS; s++) begin
                if (req[p] && !take_ok[p] && avail[s]) begin
                    take_ok[p]   = 1'b1;
                    take_slot[p] = switch_pkg::slot_t'(s);
                    avail[s]     = 1'b0;
                end
            end
            n_taken = n_taken + switch_pkg::cnt_t'(take_ok[p]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_map    <= '1;
            free_cnt    <= switch_pkg::cnt_t'(switch_pkg::NUM_SLOTS);
            grant_q     <= '0;
            ok_q        <= '0;
            full        <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            free_map    <= avail | rel_mask;
            free_cnt    <= free_cnt - n_taken + switch_pkg::cnt_t'(rel_vld);
            grant_q     <= req;
            ok_q        <= take_ok;
            full        <= (free_cnt == '0);
            almost_full <= (free_cnt <= switch_pkg::ALMOST_FULL_LEVEL);
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
            slot_q[p] <= take_slot[p];
        end
    end

    for (genvar p = 0; p < switch_pkg::NUM_PORTS; p++) begin : g_port
        assign req[p]         = alloc[p].req;
        assign alloc[p].grant = grant_q[p];
        assign alloc[p].ok    = ok_q[p];
        assign alloc[p].slot  = slot_q[p];
    end

endmodule

// ==== verilog/switch_ifs.sv ====
`timescale 1ns/1ps

// slot request from one ingress port to the allocator.
interface alloc_if;
    logic              req;
    logic              grant;
    logic              ok;    // low when no slot was free.
    switch_pkg::slot_t slot;

    modport ingress (
        output req,
        input  grant,
        input  ok,
        input  slot
    );

    modport allocator (
        input  req,
        output grant,
        output ok,
        output slot
    );
endinterface

// one write port into the packet buffer.
interface buf_wr_if;
    logic                            en;
    switch_pkg::slot_t               slot;
    switch_pkg::len_t                addr;
    logic [switch_pkg::DATA_W-1:0]   data;

    modport writer (output en, output slot, output addr, output data);
    modport memory (input en, input slot, input addr, input data);
endinterface

// ==== verilog/switch_pkg.sv ====
package switch_pkg;

    localparam int NUM_PORTS  = 4;
    localparam int NUM_SLOTS  = 16;
    localparam int SLOT_WORDS = 16;   // also the longest packet.
    localparam int DATA_W     = 16;

    // free-slot count at or below which almost_full is raised.
    localparam int ALMOST_FULL_LEVEL = 4;

    // descriptor queue per destination.
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    localparam int SLOT_CNT_W = $clog2(NUM_SLOTS + 1);

    typedef logic [$clog2(NUM_PORTS)-1:0]  port_t;
    typedef logic [$clog2(NUM_SLOTS)-1:0]  slot_t;
    typedef logic [$clog2(SLOT_WORDS)-1:0] len_t;   // word count minus one.
    typedef logic [SLOT_CNT_W-1:0]         cnt_t;

    // flat word address into the shared buffer.
    typedef logic [$bits(slot_t)+$bits(len_t)-1:0] word_addr_t;

    typedef struct packed {
        slot_t slot;
        len_t  len;
    } desc_t;

endpackage
